//--- hw/sprite_pkg.sv
package sprite_pkg;

    localparam int screen_w = 160;
    localparam int screen_h = 120;
    localparam int coord_w = 11;
    localparam int sprite_size = 10;                // Box edge of every scene object
    localparam int num_objects = 6;
    localparam int obj_idx_w = $clog2(num_objects + 1); // Also holds one past the last object

    typedef logic [coord_w-1:0] coord_t;

    // 3-bit colour, one bit each for red, green and blue
    typedef enum logic [2:0] {
        colour_black       = 3'b000,
        colour_dark_blue   = 3'b001,
        colour_light_green = 3'b010,
        colour_light_blue  = 3'b011,
        colour_red         = 3'b100,
        colour_pink        = 3'b101,
        colour_yellow      = 3'b110,
        colour_white       = 3'b111
    } colour_t;

    typedef enum logic [1:0] {
        glyph_fill,     // Whole box painted, size taken from the order
        glyph_square,   // Also used for blocks
        glyph_spike
    } glyph_t;

    typedef struct packed {
        glyph_t  glyph;
        colour_t colour;
        coord_t  x_left;
        coord_t  y_bottom;  // Lowest row of the box
        coord_t  width;
        coord_t  height;
    } draw_cmd_t;

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        colour_t colour;
    } pixel_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_clear,
        seq_object,
        seq_wait,
        seq_done
    } seq_state_t;

    // Row spans listed from the top row down
    // First index picks square (0) or spike (1)
    localparam logic [3:0] span_start [2][sprite_size] = '{
        '{4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd4, 4'd3, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0, 4'd0}
    };
    localparam logic [3:0] span_end [2][sprite_size] = '{
        '{4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9},
        '{4'd5, 4'd5, 4'd6, 4'd6, 4'd7, 4'd7, 4'd8, 4'd8, 4'd9, 4'd9}
    };

    localparam coord_t sprite_edge = coord_t'(sprite_size);

    // Full screen in black, bottom row is screen_h - 1
    localparam draw_cmd_t clear_cmd = '{glyph_fill, colour_black, coord_t'(0),
        coord_t'(screen_h - 1), coord_t'(screen_w), coord_t'(screen_h)};

    localparam draw_cmd_t scene_objects [num_objects] = '{
        '{glyph_square, colour_red,    11'd59,  11'd89, sprite_edge, sprite_edge}, // Player
        '{glyph_square, colour_yellow, 11'd69,  11'd89, sprite_edge, sprite_edge},
        '{glyph_square, colour_yellow, 11'd99,  11'd59, sprite_edge, sprite_edge},
        '{glyph_spike,  colour_white,  11'd139, 11'd89, sprite_edge, sprite_edge},
        '{glyph_spike,  colour_white,  11'd149, 11'd59, sprite_edge, sprite_edge},
        '{glyph_spike,  colour_white,  11'd159, 11'd89, sprite_edge, sprite_edge}  // Mostly off screen
    };

    // True if column col of box row row is painted for this glyph
    function automatic logic span_hit(glyph_t glyph, coord_t row, coord_t col);
        int sel;
        if (glyph == glyph_fill) begin
            return 1'b1;
        end
        if (row >= sprite_edge) begin
            return 1'b0;    // Shaped glyphs are ten rows tall
        end
        sel = (glyph == glyph_spike) ? 1 : 0;
        return (col >= coord_t'(span_start[sel][row[3:0]])) &&
               (col <= coord_t'(span_end[sel][row[3:0]]));
    endfunction

    function automatic logic on_screen(coord_t x, coord_t y);
        return (x < coord_t'(screen_w)) && (y < coord_t'(screen_h));
    endfunction

endpackage

//--- hw/frame_timer.sv
`timescale 1ns/10ps

module frame_timer #(
    parameter int ticks_per_frame = 833_333   // 50 MHz clock at 60 frames per second
) (
    input  logic clock,
    input  logic rst,
    input  logic run,
    output logic frame_tick
);
    typedef logic [$clog2(ticks_per_frame)-1:0] count_t;

    count_t count;  // Cycles left in this frame

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= count_t'(ticks_per_frame - 1);
            frame_tick <= 1'b0;
        end else begin
            frame_tick <= 1'b0;
            if (run) begin          // Frozen while stopped
                if (count == '0) begin
                    count <= count_t'(ticks_per_frame - 1);
                    frame_tick <= 1'b1;
                end else begin
                    count <= count - count_t'(1);
                end
            end
        end
    end

endmodule

//--- hw/span_rasterizer.sv
`timescale 1ns/10ps

module span_rasterizer (
    input  logic                  clock,
    input  logic                  rst,
    input  sprite_pkg::draw_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output logic                  cmd_done,
    output sprite_pkg::pixel_t    pix,
    output logic                  pix_valid,
    input  logic                  pix_ready
);
    import sprite_pkg::*;

    draw_cmd_t cmd_q;       // Order being drawn
    coord_t    row;         // Box row, 0 is the top
    coord_t    col;         // Box column, 0 is the left edge
    coord_t    cur_x;
    coord_t    cur_y;
    logic      busy;
    logic      accept;
    logic      hit;
    logic      advance;
    logic      last_col;
    logic      last_row;

    assign accept = cmd_valid && cmd_ready;
    assign cmd_ready = !busy;

    // Painted by the glyph and inside the screen
    assign hit = busy && span_hit(cmd_q.glyph, row, col) && on_screen(cur_x, cur_y);

    assign pix_valid = hit;
    assign pix.x = cur_x;
    assign pix.y = cur_y;
    assign pix.colour = cmd_q.colour;

    // A dropped position costs one cycle, a real one waits for ready
    assign advance = busy && (!hit || pix_ready);

    assign last_col = (col == cmd_q.width - coord_t'(1));
    assign last_row = (row == cmd_q.height - coord_t'(1));

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            cmd_done <= 1'b0;
            row <= '0;
            col <= '0;
        end else begin
            cmd_done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                row <= '0;
                col <= '0;
            end else if (advance) begin
                if (last_col) begin
                    col <= '0;
                    row <= row + coord_t'(1);
                    if (last_row) begin     // Whole box walked
                        busy <= 1'b0;
                        cmd_done <= 1'b1;
                    end
                end else begin
                    col <= col + coord_t'(1);
                end
            end
        end
    end

    // Screen position of the current box cell
    always_ff @(posedge clock) begin
        if (accept) begin
            cmd_q <= cmd;
            cur_x <= cmd.x_left;
            cur_y <= cmd.y_bottom - cmd.height + coord_t'(1);   // Top row
        end else if (advance) begin
            if (last_col) begin
                cur_x <= cmd_q.x_left;
                cur_y <= cur_y + coord_t'(1);
            end else begin
                cur_x <= cur_x + coord_t'(1);
            end
        end
    end

    // Stalled pixel held until taken
    assert property (@(posedge clock) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix));

    // No new order offered while one is being drawn
    assert property (@(posedge clock) disable iff (rst)
        busy |-> !cmd_valid);

endmodule

//--- hw/scene_sequencer.sv
`timescale 1ns/10ps

module scene_sequencer (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  frame_tick,
    output sprite_pkg::draw_cmd_t cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    input  logic                  cmd_done,
    output logic                  frame_done
);
    import sprite_pkg::*;

    seq_state_t           state;
    logic [obj_idx_w-1:0] obj_idx;  // Next scene object to issue

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= seq_idle;
            obj_idx <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    obj_idx <= '0;
                    if (frame_tick) begin
                        state <= seq_clear;
                    end
                end

                // Black out the screen first
                seq_clear: begin
                    if (cmd_ready) begin
                        state <= seq_wait;
                    end
                end

                seq_object: begin
                    if (cmd_ready) begin
                        state <= seq_wait;
                        obj_idx <= obj_idx + 1'b1;
                    end
                end

                // Next order only once the rasterizer is finished
                seq_wait: begin
                    if (cmd_done) begin
                        if (obj_idx == obj_idx_w'(num_objects)) begin
                            state <= seq_done;
                        end else begin
                            state <= seq_object;
                        end
                    end
                end

                seq_done: begin
                    state <= seq_idle;  // Ticks seen while busy are dropped
                end

                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    always_comb begin
        cmd_valid = (state == seq_clear) || (state == seq_object);
        if (state == seq_object) begin
            cmd = scene_objects[obj_idx];
        end else begin
            cmd = clear_cmd;
        end
    end

    assign frame_done = (state == seq_done);    // One cycle per frame

    // Rasterizer only finishes orders that were issued
    assert property (@(posedge clock) disable iff (rst)
        state == seq_idle |-> !cmd_done);

endmodule

//--- hw/frame_renderer_top.sv
`timescale 1ns/10ps

module frame_renderer_top #(
    parameter int ticks_per_frame = 833_333
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               run,
    output sprite_pkg::pixel_t pix,
    output logic               pix_valid,
    input  logic               pix_ready,
    output logic               frame_done
);
    import sprite_pkg::*;

    logic      frame_tick;
    draw_cmd_t cmd;         // Sequencer to rasterizer
    logic      cmd_valid;
    logic      cmd_ready;
    logic      cmd_done;

    frame_timer #(
        .ticks_per_frame(ticks_per_frame)
    ) timer0 (
        .clock(clock),
        .rst(rst),
        .run(run),
        .frame_tick(frame_tick)
    );

    scene_sequencer seq0 (
        .clock(clock),
        .rst(rst),
        .frame_tick(frame_tick),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .frame_done(frame_done)
    );

    span_rasterizer raster0 (
        .clock(clock),
        .rst(rst),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .pix(pix),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready)
    );

endmodule

//--- verif/frame_renderer_checks.svh
`ifndef frame_renderer_checks_svh
`define frame_renderer_checks_svh

int error_count = 0;
int check_count = 0;
int tests_run = 0;

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

task automatic report_fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    error_count++;
endtask

task automatic compare_pixel(input pixel_t actual, input pixel_t want, input int index);
    check_count++;
    if (actual !== want) begin
        report_fail($sformatf("pixel %0d is (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
            index, actual.x, actual.y, actual.colour, want.x, want.y, want.colour));
    end
endtask

task automatic compare_count(input int actual, input int want, input string what);
    check_count++;
    if (actual != want) begin
        report_fail($sformatf("%s is %0d, expected %0d", what, actual, want));
    end
endtask

task automatic compare_flag(input logic actual, input logic want, input string what);
    check_count++;
    if (actual !== want) begin
        report_fail($sformatf("%s is %b, expected %b", what, actual, want));
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, error_count - errors_before);
    end
endtask

`endif

//--- verif/frame_renderer_tb.sv
`timescale 1ns/10ps

module frame_renderer_tb;
    import sprite_pkg::*;

    localparam int clock_period = 20;
    localparam int tb_ticks = 64;
    localparam int frame_cells = screen_w * screen_h + num_objects * sprite_size * sprite_size;
    localparam int stall_factor = 3;    // Worst-case slowdown under back-pressure
    localparam int watchdog_cycles = 4 * frame_cells * stall_factor + 10_000;
    localparam int stall_period = 400;  // Ready low for the second half

    logic   clock;
    logic   rst;
    logic   run;
    logic   pix_ready;
    pixel_t pix;
    logic   pix_valid;
    logic   frame_done;

    `include "frame_renderer_checks.svh"

    pixel_t      expected [$];  // One frame from the model
    pixel_t      got [$];       // Accepted pixels
    int          done_at [$];   // Pixels accepted when frame_done was seen
    int          ready_mode;    // 0 always, 1 random, 2 long stalls
    int          stall_phase;
    logic [31:0] rng;

    frame_renderer_top #(
        .ticks_per_frame(tb_ticks)
    ) dut0 (
        .clock(clock),
        .rst(rst),
        .run(run),
        .pix(pix),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .frame_done(frame_done)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Sink side of the pixel stream
    initial begin
        pix_ready <= 1'b0;
        rng = 32'h896a;
        stall_phase = 0;
        forever begin
            @(posedge clock);
            rng = xorshift(rng);
            stall_phase = (stall_phase + 1) % stall_period;
            case (ready_mode)
                0: pix_ready <= 1'b1;
                1: pix_ready <= rng[7];
                default: pix_ready <= (stall_phase < stall_period / 2);
            endcase
        end
    end

    // Inputs only change on the rising edge, so the falling edge sees the next transfer
    always @(negedge clock) begin
        if (!rst) begin
            if (pix_valid && pix_ready) begin
                got.push_back(pix);
                if (int'(pix.x) >= screen_w || int'(pix.y) >= screen_h) begin
                    report_fail($sformatf("pixel (%0d,%0d) is off screen", pix.x, pix.y));
                end
            end
            if (frame_done) begin
                done_at.push_back(got.size());
            end
        end
    end

    function automatic pixel_t make_pixel(input int x, input int y, input colour_t colour);
        pixel_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        p.colour = colour;
        return p;
    endfunction

    // Spike widens by one column on each side every two rows
    function automatic logic painted(input glyph_t glyph, input int r, input int c);
        if (glyph == glyph_spike) begin
            return (c >= 4 - r / 2) && (c <= 5 + r / 2);
        end
        return 1'b1;
    endfunction

    task automatic build_reference();
        draw_cmd_t obj;
        int        x;
        int        y;
        int        r;
        int        c;
        int        top;
        expected.delete();
        for (y = 0; y < screen_h; y++) begin
            for (x = 0; x < screen_w; x++) begin
                expected.push_back(make_pixel(x, y, colour_black));
            end
        end
        for (int i = 0; i < num_objects; i++) begin
            obj = scene_objects[i];
            top = int'(obj.y_bottom) - sprite_size + 1;
            for (r = 0; r < sprite_size; r++) begin
                for (c = 0; c < sprite_size; c++) begin
                    x = int'(obj.x_left) + c;
                    y = top + r;
                    if (painted(obj.glyph, r, c) && x < screen_w && y < screen_h) begin
                        expected.push_back(make_pixel(x, y, obj.colour));
                    end
                end
            end
        end
    endtask

    task automatic wait_pixels(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (got.size() < n && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (got.size() < n) begin
            $display("Timed out after %0d cycles waiting for %0d pixels", limit, n);
            error_count++;
        end
    endtask

    task automatic wait_frames(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (done_at.size() < n && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (done_at.size() < n) begin
            $display("Timed out after %0d cycles waiting for frame_done %0d", limit, n);
            error_count++;
        end
    endtask

    // Run stays high until the last wanted frame has started
    task automatic run_frames(input int nframes, input int mode);
        int limit;
        limit = nframes * frame_cells * stall_factor + 1000;
        got.delete();
        done_at.delete();
        @(posedge clock);
        ready_mode <= mode;
        run <= 1'b1;
        wait_pixels((nframes - 1) * expected.size() + 1, limit);
        run <= 1'b0;
        wait_frames(nframes, limit);
        repeat (100) @(posedge clock);  // Nothing more may follow
    endtask

    task automatic check_stream(input int nframes);
        int total;
        int n;
        int i;
        total = nframes * expected.size();
        compare_count(got.size(), total, "accepted pixels");
        compare_count(done_at.size(), nframes, "frame_done pulses");
        n = (got.size() < total) ? got.size() : total;
        for (i = 0; i < n; i++) begin
            compare_pixel(got[i], expected[i % expected.size()], i);
        end
        for (i = 0; i < done_at.size(); i++) begin
            compare_count(done_at[i], (i + 1) * expected.size(), "pixels before frame_done");
        end
    endtask

    task automatic test_reset_idle();
        int errors_before;
        errors_before = error_count;
        repeat (200) begin
            @(negedge clock);
            compare_flag(pix_valid, 1'b0, "pix_valid with run low");
            compare_flag(frame_done, 1'b0, "frame_done with run low");
        end
        compare_count(got.size(), 0, "pixels with run low");
        finish_test("reset_idle", errors_before);
    endtask

    task automatic test_single_frame();
        int errors_before;
        errors_before = error_count;
        // Clear plus three squares, two full spikes and one spike column
        compare_count(expected.size(), 19_200 + 300 + 120 + 2, "model frame size");
        run_frames(1, 0);
        check_stream(1);
        finish_test("single_frame", errors_before);
    endtask

    task automatic test_spike_spans();
        int     errors_before;
        int     row_count [sprite_size];
        int     near_count;
        int     far_count;
        int     edge_count;
        int     i;
        pixel_t p;
        errors_before = error_count;
        near_count = 0;
        far_count = 0;
        edge_count = 0;
        for (i = 0; i < sprite_size; i++) begin
            row_count[i] = 0;
        end
        run_frames(1, 0);
        for (i = 0; i < got.size(); i++) begin
            p = got[i];
            if (p.colour == colour_white) begin
                if (int'(p.x) >= 139 && int'(p.x) <= 148) begin     // Spike at 139
                    near_count++;
                    if (int'(p.y) >= 80 && int'(p.y) <= 89) begin
                        row_count[int'(p.y) - 80]++;
                    end
                end else if (int'(p.x) >= 149 && int'(p.x) <= 158) begin
                    far_count++;
                end else if (int'(p.x) == 159) begin
                    edge_count++;
                    compare_flag(int'(p.y) >= 88, 1'b1, "edge spike pixel on a bottom row");
                end
            end
        end
        for (i = 0; i < sprite_size; i++) begin
            compare_count(row_count[i], 2 + 2 * (i / 2), $sformatf("spike row %0d width", i));
        end
        compare_count(near_count, 60, "pixels of spike at 139");
        compare_count(far_count, 60, "pixels of spike at 149");
        compare_count(edge_count, 2, "pixels of spike at 159");   // Only the two widest rows
        finish_test("spike_spans", errors_before);
    endtask

    task automatic test_random_ready();
        int errors_before;
        errors_before = error_count;
        run_frames(1, 1);
        check_stream(1);
        finish_test("random_ready", errors_before);
    endtask

    task automatic test_long_stalls();
        int errors_before;
        errors_before = error_count;
        run_frames(2, 2);
        check_stream(2);
        finish_test("long_stalls", errors_before);
    endtask

    initial begin
        rst <= 1'b1;
        run <= 1'b0;
        ready_mode <= 0;
        build_reference();
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        test_reset_idle();
        test_single_frame();
        test_spike_spans();
        test_random_ready();
        test_long_stalls();
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

//--- frame_renderer.f
+incdir+verif
hw/sprite_pkg.sv
hw/frame_timer.sv
hw/span_rasterizer.sv
hw/scene_sequencer.sv
hw/frame_renderer_top.sv
verif/frame_renderer_tb.sv

//--- Makefile
# Verilator build for the frame renderer testbench

VERILATOR ?= verilator
TOP       ?= frame_renderer_tb
FILELIST  ?= frame_renderer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

# Output goes to the terminal and the status comes from grep
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
